//--- src/credit_pkg.sv
// Link sizing constants, credit count type, and the flit and credit token structs.
`default_nettype none

package credit_pkg;

  // ----------------------------------------------------------
  // Link sizing
  // ----------------------------------------------------------

  // Width of one payload word carried from source to sink.
  localparam int DATA_WIDTH = 16;

  // Depth of the receiver buffer. Every slot is one credit, so this is also
  // the total number of credits that circulate between sender and receiver.
  localparam int RX_DEPTH = 8;

  // Register stages in each direction of the link.
  localparam int LINK_STAGES = 2;

  // A credit count must hold every value from 0 up to RX_DEPTH inclusive.
  localparam int COUNT_WIDTH = $clog2(RX_DEPTH + 1);

  // Buffer read and write pointers index RX_DEPTH entries.
  localparam int PTR_WIDTH = $clog2(RX_DEPTH);

  // ----------------------------------------------------------
  // Types carried on the link
  // ----------------------------------------------------------

  typedef logic [COUNT_WIDTH-1:0] count_t;

  // One word on the forward link, qualified by its valid bit.
  typedef struct packed {
    logic                  valid;
    logic [DATA_WIDTH-1:0] data;
  } flit_t;

  // One returned buffer slot on the return link.
  typedef struct packed {
    logic credit;
  } credit_t;

  // The sender starts with the whole pool and the receiver with none.
  localparam count_t TX_CREDIT_INIT = count_t'(RX_DEPTH);
  localparam count_t RX_CREDIT_INIT = '0;

endpackage

`default_nettype wire

//--- src/credit_counter.sv
// Credit counter with increment, one-per-cycle decrement, withhold and an available output.
`default_nettype none
`timescale 1ns/1ps

module credit_counter (
  input  logic                clk,
  input  logic                reset,
  // One credit coming back from the buffer this cycle.
  input  logic                incr,
  // Request to hand out one credit, and the grant for it.
  input  logic                decr_valid,
  output logic                decr_ready,
  // Value loaded while reset is high.
  input  credit_pkg::count_t  initial_value,
  // Credits that are kept back and never handed out.
  input  credit_pkg::count_t  withhold,
  // Stored value before this cycle's increment and decrement.
  output credit_pkg::count_t  value,
  // Credits that can be handed out this cycle.
  output credit_pkg::count_t  available
);

  import credit_pkg::*;

  // One extra bit so that value plus incr never wraps.
  logic [COUNT_WIDTH:0] value_plus_incr;
  logic [COUNT_WIDTH:0] withhold_wide;
  logic [COUNT_WIDTH:0] value_next;
  logic                 decr;

  // ----------------------------------------------------------
  // Available credit
  // ----------------------------------------------------------

  // An increment in this cycle already counts as available. This lets a
  // credit popped from the buffer pass straight through to the return
  // link in the same cycle, even when the stored value is zero.
  assign value_plus_incr = {1'b0, value} + {{COUNT_WIDTH{1'b0}}, incr};
  assign withhold_wide   = {1'b0, withhold};

  // The withhold is taken off the top and the result never goes below zero.
  always_comb begin
    if (value_plus_incr > withhold_wide) begin
      available = count_t'(value_plus_incr - withhold_wide);
    end else begin
      available = '0;
    end
  end

  // Only one credit leaves per cycle, so any nonzero amount is enough.
  assign decr_ready = (available != '0);
  assign decr       = decr_valid && decr_ready;

  // ----------------------------------------------------------
  // Counter state
  // ----------------------------------------------------------

  assign value_next = value_plus_incr - {{COUNT_WIDTH{1'b0}}, decr};

  // In reset the counter loads its start value and drops any increment.
  always_ff @(posedge clk) begin
    if (reset) begin
      value <= initial_value;
    end else begin
      value <= count_t'(value_next);
    end
  end

endmodule

`default_nettype wire

//--- src/credit_receiver.sv
// Receiver side of the credit flow: flit pass-through and return of popped buffer credits.
`default_nettype none
`timescale 1ns/1ps

module credit_receiver (
  input  logic                clk,
  input  logic                reset,

  // Flit arriving from the forward link.
  input  credit_pkg::flit_t   push_flit,
  // Same flit handed to the receiver buffer in the same cycle.
  output credit_pkg::flit_t   pop_flit,

  // One slot freed by the buffer this cycle.
  input  logic                pop_credit,

  // While high, credits stay in the counter and nothing is returned.
  input  logic                credit_stall,
  // Credit token driven into the return link.
  output credit_pkg::credit_t push_credit,

  // Credits held back from circulation.
  input  credit_pkg::count_t  credit_withhold,
  // Counter value and the amount that could be returned now.
  output credit_pkg::count_t  credit_count,
  output credit_pkg::count_t  credit_available
);

  import credit_pkg::*;

  logic decr_valid;
  logic decr_ready;

  // ----------------------------------------------------------
  // Datapath
  // ----------------------------------------------------------

  // No register sits between push and pop. A flit that arrives during
  // reset is dropped, so the buffer never sees a write while the two
  // sides are reloading their credit state.
  assign pop_flit = '{valid: push_flit.valid && !reset, data: push_flit.data};

  // ----------------------------------------------------------
  // Credit return
  // ----------------------------------------------------------

  // The counter is always asked for a credit unless the return is stalled.
  assign decr_valid = !credit_stall;

  // The receiver starts with no credits. The whole pool is at the sender.
  credit_counter u_counter (
    .clk           (clk),
    .reset         (reset),
    .incr          (pop_credit),
    .decr_valid    (decr_valid),
    .decr_ready    (decr_ready),
    .initial_value (RX_CREDIT_INIT),
    .withhold      (credit_withhold),
    .value         (credit_count),
    .available     (credit_available)
  );

  // A granted decrement becomes one credit on the return link. Nothing is
  // sent in reset, because the sender reloads its full count at that time
  // and a credit in flight would be counted twice.
  assign push_credit = '{credit: decr_valid && decr_ready && !reset};

endmodule

`default_nettype wire

//--- src/link_delay.sv
// Fixed-length register pipeline that models a multi-cycle link wire for any payload type.
`default_nettype none
`timescale 1ns/1ps

module link_delay #(
  // Payload carried by the link. The forward link carries flits and the
  // return link carries credit tokens.
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     reset,
  input  payload_t in,
  output payload_t out
);

  import credit_pkg::*;

  // One register per stage. Each stage holds its own item, so
  // LINK_STAGES items can be in flight at the same time.
  payload_t stage [LINK_STAGES];

  // ----------------------------------------------------------
  // Shift chain
  // ----------------------------------------------------------

  // Clearing every stage in reset drops all flits and credits that were
  // on the wire. The valid and credit bits are part of the payload, so a
  // zero payload is an empty slot.
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < LINK_STAGES; i++) begin
        stage[i] <= '0;
      end
    end else begin
      stage[0] <= in;
      for (int i = 1; i < LINK_STAGES; i++) begin
        stage[i] <= stage[i-1];
      end
    end
  end

  // The far end sees the last stage.
  assign out = stage[LINK_STAGES-1];

endmodule

`default_nettype wire

//--- src/rx_buffer.sv
// Receiver FIFO written by incoming flits, drained by valid/ready, one credit per pop.
`default_nettype none
`timescale 1ns/1ps

module rx_buffer (
  input  logic                             clk,
  input  logic                             reset,
  // Write side. There is no ready, since the sender never overruns the credit pool.
  input  credit_pkg::flit_t                wr_flit,
  // Read side with a valid/ready handshake.
  output logic                             out_valid,
  output logic [credit_pkg::DATA_WIDTH-1:0] out_data,
  input  logic                             out_ready,
  // High in each cycle where a word leaves, which frees one slot.
  output logic                             pop_credit
);

  import credit_pkg::*;

  logic [DATA_WIDTH-1:0] mem [RX_DEPTH];
  logic [PTR_WIDTH-1:0]  wr_ptr;
  logic [PTR_WIDTH-1:0]  rd_ptr;
  count_t                count;
  logic                  push;
  logic                  pop;

  assign push = wr_flit.valid;
  assign pop  = out_valid && out_ready;

  // ----------------------------------------------------------
  // Storage
  // ----------------------------------------------------------

  // Entries are plain registers. The head entry is read straight from
  // them, so a word written into an empty buffer is seen one cycle later.
  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= wr_flit.data;
    end
  end

  assign out_valid  = (count != '0);
  assign out_data   = mem[rd_ptr];
  assign pop_credit = pop;

  // ----------------------------------------------------------
  // Pointers and occupancy
  // ----------------------------------------------------------

  // Pointers wrap at RX_DEPTH. A push and a pop in one cycle leave the count as it is.
  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_WIDTH'(RX_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_WIDTH'(RX_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      count <= count + count_t'(push) - count_t'(pop);
    end
  end

endmodule

`default_nettype wire

//--- src/credit_sender.sv
// Sender side of the credit flow: credit count, source acceptance and registered flit push.
`default_nettype none
`timescale 1ns/1ps

module credit_sender (
  input  logic                              clk,
  input  logic                              reset,
  // Source side with a valid/ready handshake.
  input  logic                              src_valid,
  input  logic [credit_pkg::DATA_WIDTH-1:0] src_data,
  output logic                              src_ready,
  // Credit token coming back from the return link.
  input  credit_pkg::credit_t               ret_credit,
  // Registered flit into the forward link.
  output credit_pkg::flit_t                 push_flit,
  // Credits the sender currently holds.
  output credit_pkg::count_t                sender_credits
);

  import credit_pkg::*;

  logic   accept;
  count_t credits_next;

  // A word is taken only when a credit is held, and each word spends one.
  assign accept = src_valid && src_ready;

  // A returned credit and a spent credit can both happen in one cycle.
  assign credits_next = sender_credits + count_t'(ret_credit.credit) - count_t'(accept);

  // ----------------------------------------------------------
  // Credit state and ready
  // ----------------------------------------------------------

  // Ready is kept as a flop that tracks the next count. It is low through
  // reset and rises on the first edge after reset is released. From then
  // on it is high exactly while the count is not zero.
  always_ff @(posedge clk) begin
    if (reset) begin
      sender_credits <= TX_CREDIT_INIT;
      src_ready      <= 1'b0;
    end else begin
      sender_credits <= credits_next;
      src_ready      <= (credits_next != '0);
    end
  end

  // ----------------------------------------------------------
  // Flit register
  // ----------------------------------------------------------

  // Only the valid bit is cleared. The data field just holds the last word.
  always_ff @(posedge clk) begin
    if (reset) begin
      push_flit.valid <= 1'b0;
    end else begin
      push_flit.valid <= accept;
      if (accept) begin
        push_flit.data <= src_data;
      end
    end
  end

endmodule

`default_nettype wire

//--- src/credit_link_top.sv
// Top level of the credit link: sender, forward and return links, receiver and buffer.
`default_nettype none
`timescale 1ns/1ps

module credit_link_top (
  input  logic                              clk,
  input  logic                              reset,
  input  logic                              src_valid,
  input  logic [credit_pkg::DATA_WIDTH-1:0] src_data,
  output logic                              src_ready,
  output logic                              out_valid,
  output logic [credit_pkg::DATA_WIDTH-1:0] out_data,
  input  logic                              out_ready,
  input  credit_pkg::count_t                credit_withhold,
  input  logic                              credit_stall,
  output credit_pkg::count_t                sender_credits,
  output credit_pkg::count_t                credit_count,
  output credit_pkg::count_t                credit_available
);

  import credit_pkg::*;

  // Forward path, from sender to buffer.
  flit_t   tx_flit;
  flit_t   rx_flit;
  flit_t   buf_flit;
  // Return path, from buffer back to sender.
  logic    pop_credit;
  credit_t rx_credit;
  credit_t tx_credit;

  credit_sender u_sender (
    .clk(clk), .reset(reset),
    .src_valid(src_valid), .src_data(src_data), .src_ready(src_ready),
    .ret_credit(tx_credit), .push_flit(tx_flit), .sender_credits(sender_credits)
  );

  link_delay #(.payload_t(flit_t)) fwd_link (
    .clk(clk), .reset(reset), .in(tx_flit), .out(rx_flit)
  );

  credit_receiver u_receiver (
    .clk(clk), .reset(reset),
    .push_flit(rx_flit), .pop_flit(buf_flit), .pop_credit(pop_credit),
    .credit_stall(credit_stall), .push_credit(rx_credit),
    .credit_withhold(credit_withhold), .credit_count(credit_count),
    .credit_available(credit_available)
  );

  rx_buffer u_buffer (
    .clk(clk), .reset(reset), .wr_flit(buf_flit),
    .out_valid(out_valid), .out_data(out_data), .out_ready(out_ready),
    .pop_credit(pop_credit)
  );

  link_delay #(.payload_t(credit_t)) ret_link (
    .clk(clk), .reset(reset), .in(rx_credit), .out(tx_credit)
  );

endmodule

`default_nettype wire

//--- tests/credit_link_checker.sv
// Credit link checker for delivery order, occupancy, credit stall, reset state and rest levels.
`default_nettype none
`timescale 1ns/1ps

module credit_link_checker (
  input logic                              clk,
  input logic                              reset,
  input logic                              src_ready,
  input logic                              out_valid,
  input logic [credit_pkg::DATA_WIDTH-1:0] out_data,
  input logic                              out_ready,
  input logic                              credit_stall,
  input credit_pkg::count_t                credit_withhold,
  input credit_pkg::count_t                sender_credits,
  input credit_pkg::count_t                credit_count,
  input credit_pkg::count_t                credit_available
);

  import credit_pkg::*;

  // Accepted words that are not yet delivered, oldest first.
  logic [DATA_WIDTH-1:0] expected_q [$];
  int     error_count  = 0;
  int     stall_cycles = 0;
  logic   prev_reset   = 1'b1;
  logic   prev_stall   = 1'b0;
  logic   prev_pop     = 1'b0;
  count_t prev_count   = '0;
  count_t prev_credits = '0;

  task automatic compare(input string name, input int actual, input int expected);
    if (actual != expected) begin
      $display("FAIL time=%0t signal=%s expected=0x%0h actual=0x%0h", $time, name, expected,
               actual);
      error_count++;
    end
  endtask

  // ----------------------------------------------------------
  // Called from the testbench
  // ----------------------------------------------------------

  // After a settling idle nothing is in flight. Every credit then sits at
  // the sender, in the receiver counter, or as a word held in the buffer.
  task automatic check_at_rest(input int expected_credits);
    int available_expected;
    // With nothing popped, the counter offers only what lies above the withhold.
    available_expected = (int'(credit_count) > int'(credit_withhold)) ?
                         int'(credit_count) - int'(credit_withhold) : 0;
    compare("sender_credits", int'(sender_credits), expected_credits);
    compare("sender_credits+credit_count", int'(sender_credits) + int'(credit_count),
            RX_DEPTH - expected_q.size());
    compare("credit_available", int'(credit_available), available_expected);
  endtask

  task automatic check_drained();
    if (expected_q.size() != 0) begin
      $display("ERROR: %0d accepted words were never delivered", expected_q.size());
      error_count++;
    end
  endtask

  // ----------------------------------------------------------
  // Cycle checks
  // ----------------------------------------------------------

  // Inputs move 1 ns after the rising edge, so values are settled at the falling edge.
  always @(negedge clk) begin
    int                    count_expected;
    logic [DATA_WIDTH-1:0] head;
    if (!reset && prev_reset) begin
      compare("out_valid", int'(out_valid), 0);
      compare("sender_credits", int'(sender_credits), RX_DEPTH);
      compare("credit_count", int'(credit_count), 0);
    end else if (!reset) begin
      // A stalled counter only gathers the credits of popped words.
      if (prev_stall) begin
        count_expected = int'(prev_count) + int'(prev_pop);
        count_expected = (count_expected > RX_DEPTH) ? RX_DEPTH : count_expected;
        compare("credit_count", int'(credit_count), count_expected);
      end
      // Credits still on the return link may land during the first cycles of a stall.
      if (stall_cycles > LINK_STAGES && sender_credits > prev_credits) begin
        $display("ERROR: sender_credits rose from %0d to %0d at %0t during a credit stall",
                 prev_credits, sender_credits, $time);
        error_count++;
      end
      if (expected_q.size() > RX_DEPTH) begin
        $display("ERROR: %0d words outstanding at %0t, more than the buffer can hold",
                 expected_q.size(), $time);
        error_count++;
      end
      if (expected_q.size() == RX_DEPTH) begin
        compare("src_ready", int'(src_ready), 0);
      end
      if (out_valid && out_ready) begin
        if (expected_q.size() == 0) begin
          $display("ERROR: a word was delivered at %0t with no accepted word outstanding", $time);
          error_count++;
        end else begin
          head = expected_q.pop_front();
          compare("out_data", int'(out_data), int'(head));
        end
      end
    end
    stall_cycles = (!reset && credit_stall) ? stall_cycles + 1 : 0;
    prev_reset   = reset;
    prev_stall   = credit_stall;
    prev_pop     = out_valid && out_ready;
    prev_count   = credit_count;
    prev_credits = sender_credits;
  end

endmodule

`default_nettype wire

//--- tests/credit_link_tb.sv
// Testbench top with clock, reset, file-driven stimulus and random gaps, watchdog and summary.
`default_nettype none
`timescale 1ns/1ps

module credit_link_tb;

  import credit_pkg::*;

  localparam int CLK_PERIOD = 8;

  logic                  clk = 1'b0;
  logic                  reset;
  logic                  src_valid;
  logic [DATA_WIDTH-1:0] src_data;
  logic                  src_ready;
  logic                  out_valid;
  logic [DATA_WIDTH-1:0] out_data;
  logic                  out_ready;
  count_t                credit_withhold;
  logic                  credit_stall;
  count_t                sender_credits;
  count_t                credit_count;
  count_t                credit_available;

  // Random state for gaps and out_ready drops, and the out_ready level set by CFG.
  logic [31:0] rnd_state = 32'd20752;
  logic        cfg_ready = 1'b1;
  int          tb_errors = 0;

  always #(CLK_PERIOD / 2) clk = ~clk;

  credit_link_top dut (.*);
  credit_link_checker chk (.*);

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    return y ^ (y << 5);
  endfunction

  // One clock step. During a burst out_ready drops on about one cycle in eight.
  task automatic step_clock(input logic jitter);
    @(posedge clk);
    #1;
    rnd_state = xorshift32(rnd_state);
    out_ready = cfg_ready && !(jitter && rnd_state[2:0] == 3'd0);
  endtask

  // Offers one word until it is taken, then waits 0 to 3 idle cycles.
  task automatic send_word(input logic [DATA_WIDTH-1:0] data);
    logic accepted;
    accepted  = 1'b0;
    src_valid = 1'b1;
    src_data  = data;
    while (!accepted) begin
      @(negedge clk);
      accepted = src_ready;
      step_clock(1'b1);
    end
    src_valid = 1'b0;
    chk.expected_q.push_back(data);
    repeat (int'(rnd_state[4:3])) step_clock(1'b1);
  endtask

  initial begin
    int     fd;
    int     data, rdy, whold, stall, hold, expected;
    longint limit;
    string  line;
    string  cmd;
    string  steps [$];
    reset           = 1'b1;
    src_valid       = 1'b0;
    src_data        = '0;
    out_ready       = 1'b1;
    credit_withhold = '0;
    credit_stall    = 1'b0;
    limit           = 0;
    fd = $fopen("tests/credit_link_input.txt", "r");
    if (fd == 0) begin
      $display("ERROR: cannot open the stimulus file tests/credit_link_input.txt");
      tb_errors++;
    end
    // Keep the step lines and size the watchdog from their hold counts.
    while (fd != 0 && !$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      if (line.substr(0, 0) != "#" &&
          $sscanf(line, "%s %h %d %d %d %d %d", cmd, data, rdy, whold, stall, hold, expected) == 7)
      begin
        steps.push_back(line);
        limit += hold + 64;
      end
    end
    if (fd != 0) begin
      $fclose(fd);
    end
    fork
      begin
        #(limit * CLK_PERIOD);
        $display("ERROR: watchdog expired after %0d cycles, the test stopped making progress",
                 limit);
        $display("RESULT: FAIL");
        $finish;
      end
    join_none
    repeat (2) @(posedge clk);
    #1;
    reset = 1'b0;
    foreach (steps[i]) begin
      void'($sscanf(steps[i], "%s %h %d %d %d %d %d",
                    cmd, data, rdy, whold, stall, hold, expected));
      if (cmd == "SEND") begin
        for (int j = 0; j < hold; j++) begin
          send_word(DATA_WIDTH'(data + j));
        end
        out_ready = cfg_ready;
      end else if (cmd == "IDLE") begin
        repeat (hold) step_clock(1'b0);
      end else if (cmd == "CFG") begin
        cfg_ready       = rdy[0];
        out_ready       = rdy[0];
        credit_withhold = count_t'(whold);
        credit_stall    = stall[0];
      end else if (cmd == "RESET") begin
        // Words still in the link or the buffer are dropped by the reset.
        reset = 1'b1;
        chk.expected_q.delete();
        repeat (hold) step_clock(1'b0);
        reset = 1'b0;
      end else if (cmd == "CHECK") begin
        @(negedge clk);
        #1;
        chk.check_at_rest(expected);
        step_clock(1'b0);
      end else begin
        $display("ERROR: unknown command %s in the stimulus file", cmd);
        tb_errors++;
      end
    end
    chk.check_drained();
    $display("Errors: %0d from the checker, %0d from the testbench", chk.error_count, tb_errors);
    if (chk.error_count == 0 && tb_errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog.f
src/credit_pkg.sv
src/credit_counter.sv
src/credit_receiver.sv
src/link_delay.sv
src/rx_buffer.sv
src/credit_sender.sv
src/credit_link_top.sv
tests/credit_link_checker.sv
tests/credit_link_tb.sv

//--- run.sh
#!/bin/sh
# Build the testbench with Verilator, run it into sim.log and look for the pass line.
cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal --top-module credit_link_tb -f verilog.f \
  -o credit_link_sim > build.log 2>&1 &&
./obj_dir/credit_link_sim > sim.log 2>&1 &&
grep -q "^RESULT: PASS$" sim.log &&
echo "Simulation passed." ||
{ echo "Simulation failed, see build.log and sim.log."; exit 1; }

//--- tests/credit_link_input.txt
# cmd data rdy whold stall hold exp  (SEND sends hold words counting up from data)
# RESET holds reset for hold cycles. CHECK compares exp with sender_credits at rest.
CFG   0000 1 0 0 0  0
SEND  a000 0 0 0 10 0
IDLE  0000 0 0 0 12 0
CHECK 0000 0 0 0 0  8
CFG   0000 0 0 0 0  0
SEND  b000 0 0 0 8  0
IDLE  0000 0 0 0 12 0
CHECK 0000 0 0 0 0  0
CFG   0000 1 3 0 0  0
SEND  c000 0 0 0 6  0
IDLE  0000 0 0 0 16 0
CHECK 0000 0 0 0 0  5
CFG   0000 1 0 1 0  0
SEND  d000 0 0 0 4  0
IDLE  0000 0 0 0 12 0
CHECK 0000 0 0 0 0  1
CFG   0000 1 0 0 0  0
IDLE  0000 0 0 0 16 0
CHECK 0000 0 0 0 0  8
CFG   0000 0 0 0 0  0
SEND  e000 0 0 0 4  0
RESET 0000 0 0 0 2  0
CFG   0000 1 0 0 0  0
SEND  f000 0 0 0 6  0
IDLE  0000 0 0 0 12 0
CHECK 0000 0 0 0 0  8
